//--- all.f
+incdir+test
design/calc_pkg.sv
design/calc_bypass.sv
design/calc_pipe_int.sv
design/calc_pipe_mul.sv
design/calc_pipe_long.sv
design/calc_completion.sv
design/calc_top.sv
test/calc_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= calc_tb
FILELIST  ?= all.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- test/calc_tb_model.svh
/* Reference model, random source and compare task for the calc_top testbench.
   Included inside the testbench module after its counters are declared. */
`ifndef CALC_TB_MODEL_SVH
`define CALC_TB_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Result of one op on its two operands, b is already imm or rs2
function automatic logic [DATA_W-1:0] op_result(input calc_op_e op, input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b);
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_AND:  return a & b;
    OP_OR:   return a | b;
    OP_XOR:  return a ^ b;
    OP_SLL:  return a << b[4:0];
    OP_SRL:  return a >> b[4:0];
    OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP_MUL:  return a * b;
    OP_DIVU: return (b == '0) ? '1 : a / b;
    OP_REMU: return (b == '0) ? a : a % b;
    OP_BEQ:  return (a == b) ? 32'd1 : 32'd0;
    OP_BNE:  return (a != b) ? 32'd1 : 32'd0;
    default: return '0;
  endcase
endfunction

task automatic check(input string what, input logic [63:0] got, input logic [63:0] expected);
  checks++;
  if (got !== expected)
  begin
    errors++;
    $display("ERROR %0t: %s got %h expected %h", $time, what, got, expected);
  end
endtask

`endif

//--- test/calc_tb.sv
/* Testbench for calc_top. Drives random dispatch packets with stale register
   data and checks writeback, branch and commit outputs against an in-order model. */
`timescale 1ns/100ps

module calc_tb;

  import calc_pkg::*;

  localparam int N_ALU = 200;
  localparam int N_MUL = 30;
  localparam int N_LONG = 4;
  localparam int LONG_SLOTS = 40;
  localparam int N_BR = 20;
  localparam int N_ILL = 15;
  localparam int WATCHDOG_CYC = (N_ALU + 2*N_MUL + N_LONG*(1+LONG_SLOTS) + N_BR + N_ILL) * 40;

  logic          clk;
  logic          rst_n_i;
  dispatch_pkt_s dispatch_pkt_i;
  logic          long_ready_o;
  wb_pkt_s       iwb_pkt_o;
  br_pkt_s       br_pkt_o;
  commit_pkt_s   commit_pkt_o;

  int          errors = 0;
  int          checks = 0;
  int          start_errors = 0;
  int          ntests = 0;
  int          cyc = 0;
  logic [31:0] rnd = 32'h0d3f_89f1;
  logic [31:0] pc = 32'h1000;
  logic [DATA_W-1:0] regs [32];
  logic [DATA_W-1:0] model_regs [32];
  int          iwb_cyc_q[$];
  wb_pkt_s     iwb_exp_q[$];
  int          br_cyc_q[$];
  br_pkt_s     br_exp_q[$];
  int          commit_cyc_q[$];
  commit_pkt_s commit_exp_q[$];
  logic        long_pending = 1'b0;
  wb_pkt_s     long_exp;

  `include "calc_tb_model.svh"

  calc_top calc_top_i
    (.clk_i(clk), .rst_n_i(rst_n_i), .dispatch_pkt_i(dispatch_pkt_i),
     .long_ready_o(long_ready_o), .iwb_pkt_o(iwb_pkt_o), .br_pkt_o(br_pkt_o),
     .commit_pkt_o(commit_pkt_o));

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rnd = xorshift32(rnd);
    return rnd;
  endfunction

  // Drive one instruction on the falling edge and record what it must produce
  task automatic issue(input calc_op_e op, input logic use_imm, input logic illegal,
                       input int rd, input int rs1a, input int rs2a, input logic [31:0] imm);
    dispatch_pkt_s pkt;
    int            t;
    logic [31:0]   a;
    logic [31:0]   b;
    logic [31:0]   res;
    @(negedge clk);
    pkt = '{v: 1'b1, pc: pc, op: op, use_imm: use_imm, illegal: illegal,
            rd_addr: rd[4:0], rs1_addr: rs1a[4:0], rs2_addr: rs2a[4:0],
            rs1: regs[rs1a], rs2: regs[rs2a], imm: imm};
    dispatch_pkt_i = pkt;
    t = cyc + 1;
    a = model_regs[rs1a];
    b = use_imm ? imm : model_regs[rs2a];
    res = op_result(op, a, b);
    commit_cyc_q.push_back(t + 4);
    commit_exp_q.push_back('{v: 1'b1, illegal: illegal, pc: pc});
    if (!illegal)
    begin
      if (op inside {OP_BEQ, OP_BNE})
      begin
        br_cyc_q.push_back(t + 2);
        br_exp_q.push_back('{v: 1'b1, taken: res[0], target: pc + imm});
      end
      else if (op inside {OP_DIVU, OP_REMU})
      begin
        long_exp = '{w_v: 1'b1, rd_addr: rd[4:0], rd_data: res};
        long_pending = 1'b1;
      end
      else
      begin
        iwb_cyc_q.push_back(t + 4);
        iwb_exp_q.push_back('{w_v: 1'b1, rd_addr: rd[4:0], rd_data: res});
      end
      if (!(op inside {OP_BEQ, OP_BNE}) && rd != 0)
        model_regs[rd] = res;
    end
    pc = pc + 4;
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(negedge clk);
      dispatch_pkt_i.v = 1'b0;
    end
  endtask

  task automatic random_alu(input int max_reg);
    issue(calc_op_e'(next_rand() % 8), next_rand() % 2, 1'b0, next_rand() % max_reg,
          next_rand() % max_reg, next_rand() % max_reg, next_rand());
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d errors", name, errors - start_errors);
    start_errors = errors;
    ntests++;
  endtask

  // Outputs are sampled on the rising edge before they update
  always @(posedge clk)
  begin : compare_blk
    wb_pkt_s exp_wb;
    cyc = cyc + 1;
    if (rst_n_i)
    begin
      if (iwb_cyc_q.size() > 0 && iwb_cyc_q[0] == cyc)
      begin
        exp_wb = iwb_exp_q.pop_front();
        void'(iwb_cyc_q.pop_front());
        check("iwb", iwb_pkt_o, exp_wb);
      end
      else if (long_pending && iwb_pkt_o.w_v)
      begin
        check("long wb", iwb_pkt_o, long_exp);
        long_pending = 1'b0;
      end
      else
        check("iwb valid", iwb_pkt_o.w_v, 0);
      if (iwb_pkt_o.w_v === 1'b1 && iwb_pkt_o.rd_addr != 0)
        regs[iwb_pkt_o.rd_addr] = iwb_pkt_o.rd_data;
      if (br_cyc_q.size() > 0 && br_cyc_q[0] == cyc)
      begin
        void'(br_cyc_q.pop_front());
        check("br", br_pkt_o, br_exp_q.pop_front());
      end
      else
        check("br valid", br_pkt_o.v, 0);
      if (commit_cyc_q.size() > 0 && commit_cyc_q[0] == cyc)
      begin
        void'(commit_cyc_q.pop_front());
        check("commit", commit_pkt_o, commit_exp_q.pop_front());
      end
      else
        check("commit valid", commit_pkt_o.v, 0);
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYC);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    rst_n_i = 1'b0;
    dispatch_pkt_i = '0;
    regs[0] = '0;
    model_regs[0] = '0;
    for (int i = 1; i < 32; i++)
    begin
      regs[i] = next_rand();
      model_regs[i] = regs[i];
    end

    for (int i = 0; i < 5; i++)
    begin
      @(negedge clk);
      check("reset iwb v", iwb_pkt_o.w_v, 0);
      check("reset commit v", commit_pkt_o.v, 0);
      check("reset br v", br_pkt_o.v, 0);
      check("reset long ready", long_ready_o, 1);
      if (i == 3)
        rst_n_i = 1'b1;
    end
    finish_test("test 1 reset");

    for (int k = 0; k < N_ALU; k++)
      random_alu(16);
    idle(6);
    finish_test("test 2 random alu");

    for (int k = 0; k < N_MUL; k++)
    begin
      int rd;
      rd = 1 + next_rand() % 15;
      issue(OP_MUL, 1'b0, 1'b0, rd, next_rand() % 16, next_rand() % 16, 0);
      idle(2);
      issue(OP_ADD, 1'b1, 1'b0, next_rand() % 16, rd, 0, next_rand() % 64);
    end
    idle(6);
    finish_test("test 3 mul");

    // Long ops write regs 24 and up while traffic stays below 16
    for (int k = 0; k < N_LONG; k++)
    begin
      while (!long_ready_o)
        idle(1);
      issue(k[0] ? OP_REMU : OP_DIVU, 1'b0, 1'b0, 24 + k, 16 + next_rand() % 8,
            (k >= 2) ? 0 : 16 + next_rand() % 8, 0);
      for (int s = 0; s < LONG_SLOTS; s++)
      begin
        if (next_rand() % 2)
          random_alu(16);
        else
          idle(1);
        if (s >= 1 && long_pending)
          check("long ready busy", long_ready_o, 0);
      end
      while (long_pending)
        idle(1);
    end
    idle(6);
    finish_test("test 4 long");

    for (int k = 0; k < N_BR; k++)
    begin
      int r1;
      r1 = next_rand() % 16;
      issue(next_rand() % 2 ? OP_BEQ : OP_BNE, 1'b0, 1'b0, 1 + next_rand() % 15, r1,
            next_rand() % 2 ? r1 : next_rand() % 16, next_rand());
    end
    idle(6);
    finish_test("test 5 branch");

    for (int k = 0; k < N_ILL - 1; k++)
      issue(calc_op_e'(next_rand() % 13), 1'b0, 1'b1, 1 + next_rand() % 15,
            next_rand() % 16, next_rand() % 16, next_rand());
    // A flagged divide must leave the long pipe idle
    issue(OP_DIVU, 1'b0, 1'b1, 1, 1, 2, 0);
    idle(2);
    check("ready after illegal", long_ready_o, 1);
    idle(6);
    if (iwb_cyc_q.size() + br_cyc_q.size() + commit_cyc_q.size() != 0 || long_pending)
    begin
      errors++;
      $display("Expected outputs never arrived from the DUT");
    end
    finish_test("test 6 illegal");

    $display("tests %0d, checks %0d, errors %0d", ntests, checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- design/calc_top.sv
/* Integer execution back end. Takes one dispatch packet per cycle into the
   reservation register and retires it through the completion pipeline. */
`timescale 1ns/100ps

module calc_top
  (input                             clk_i
   , input                           rst_n_i
   , input  calc_pkg::dispatch_pkt_s dispatch_pkt_i
   , output logic                    long_ready_o
   , output calc_pkg::wb_pkt_s       iwb_pkt_o
   , output calc_pkg::br_pkt_s       br_pkt_o
   , output calc_pkg::commit_pkt_s   commit_pkt_o
   );

  import calc_pkg::*;

  dispatch_pkt_s                    reservation_n;
  dispatch_pkt_s                    reservation_r;
  wb_pkt_s [STAGE_ELS-1:0]          stage_r;
  logic [STAGE_ELS-1:0][DATA_W-1:0] stage_data_n;
  logic [DATA_W-1:0]                int_data;
  logic [DATA_W-1:0]                mul_data;
  logic                             int_v;
  logic                             mul_v;
  logic                             long_v;
  logic                             long_yumi;
  wb_pkt_s                          long_wb_pkt;

  calc_bypass calc_bypass_i
    (.dispatch_i       (dispatch_pkt_i)
     , .stage_r_i      (stage_r)
     , .stage_data_n_i (stage_data_n)
     , .reservation_n_o(reservation_n)
     );

  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
    if (!rst_n_i)
      reservation_r.v <= 1'b0;
  end

  calc_pipe_int calc_pipe_int_i
    (.clk_i          (clk_i)
     , .rst_n_i      (rst_n_i)
     , .reservation_i(reservation_r)
     , .data_o       (int_data)
     , .v_o          (int_v)
     , .br_pkt_o     (br_pkt_o)
     );

  calc_pipe_mul calc_pipe_mul_i
    (.clk_i          (clk_i)
     , .rst_n_i      (rst_n_i)
     , .reservation_i(reservation_r)
     , .data_o       (mul_data)
     , .v_o          (mul_v)
     );

  calc_pipe_long calc_pipe_long_i
    (.clk_i          (clk_i)
     , .rst_n_i      (rst_n_i)
     , .reservation_i(reservation_r)
     , .yumi_i       (long_yumi)
     , .ready_o      (long_ready_o)
     , .wb_pkt_o     (long_wb_pkt)
     , .v_o          (long_v)
     );

  calc_completion calc_completion_i
    (.clk_i            (clk_i)
     , .rst_n_i        (rst_n_i)
     , .reservation_n_i(reservation_n)
     , .int_data_i     (int_data)
     , .int_v_i        (int_v)
     , .mul_data_i     (mul_data)
     , .mul_v_i        (mul_v)
     , .long_wb_pkt_i  (long_wb_pkt)
     , .long_v_i       (long_v)
     , .stage_r_o      (stage_r)
     , .stage_data_n_o (stage_data_n)
     , .long_yumi_o    (long_yumi)
     , .iwb_pkt_o      (iwb_pkt_o)
     , .commit_pkt_o   (commit_pkt_o)
     );

endmodule

//--- design/calc_completion.sv
/* Completion and exception pipeline. Carries each instruction to commit, merges
   pipe results by latency and picks the long result for free writeback slots. */
`timescale 1ns/100ps

module calc_completion
  (input                                                            clk_i
   , input                                                          rst_n_i
   , input  calc_pkg::dispatch_pkt_s                                reservation_n_i
   , input  logic [calc_pkg::DATA_W-1:0]                            int_data_i
   , input                                                          int_v_i
   , input  logic [calc_pkg::DATA_W-1:0]                            mul_data_i
   , input                                                          mul_v_i
   , input  calc_pkg::wb_pkt_s                                      long_wb_pkt_i
   , input                                                          long_v_i
   , output calc_pkg::wb_pkt_s [calc_pkg::STAGE_ELS-1:0]            stage_r_o
   , output logic [calc_pkg::STAGE_ELS-1:0][calc_pkg::DATA_W-1:0]   stage_data_n_o
   , output logic                                                   long_yumi_o
   , output calc_pkg::wb_pkt_s                                      iwb_pkt_o
   , output calc_pkg::commit_pkt_s                                  commit_pkt_o
   );

  import calc_pkg::*;

  wb_pkt_s    [STAGE_ELS:0]   stage_n;
  wb_pkt_s    [STAGE_ELS-1:0] stage_r;
  exc_stage_s [STAGE_ELS-1:0] exc_n;
  exc_stage_s [STAGE_ELS-1:0] exc_r;
  logic                       writes_rd;

  // Branches write nothing, long ops write later through the grant
  assign writes_rd = ~reservation_n_i.illegal
                     & ~(reservation_n_i.op inside {OP_BEQ, OP_BNE, OP_DIVU, OP_REMU});

  always_comb
  begin
    stage_n[0].w_v     = reservation_n_i.v & writes_rd;
    stage_n[0].rd_addr = reservation_n_i.rd_addr;
    stage_n[0].rd_data = '0;
    for (int i = 1; i <= STAGE_ELS; i++)
      stage_n[i] = stage_r[i-1];
    stage_n[1].rd_data           |= int_v_i ? int_data_i : '0;
    stage_n[MUL_LATENCY].rd_data |= mul_v_i ? mul_data_i : '0;
  end

  always_comb
  begin
    exc_n[0].v       = reservation_n_i.v;
    exc_n[0].illegal = reservation_n_i.illegal;
    exc_n[0].pc      = reservation_n_i.pc;
    for (int i = 1; i < STAGE_ELS; i++)
      exc_n[i] = exc_r[i-1];
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= stage_n[STAGE_ELS-1:0];
    exc_r   <= exc_n;
    if (!rst_n_i)
    begin
      for (int i = 0; i < STAGE_ELS; i++)
      begin
        stage_r[i].w_v <= 1'b0;
        exc_r[i].v     <= 1'b0;
      end
    end
  end

  // Forward each stage's data as it will be once this cycle's merge lands
  always_comb
  begin
    for (int i = 0; i < STAGE_ELS; i++)
      stage_data_n_o[i] = stage_n[i+1].rd_data;
  end

  assign stage_r_o   = stage_r;
  assign long_yumi_o = long_v_i & ~stage_r[STAGE_ELS-1].w_v;
  assign iwb_pkt_o   = long_yumi_o ? long_wb_pkt_i : stage_r[STAGE_ELS-1];

  always_comb
  begin
    commit_pkt_o.v       = exc_r[STAGE_ELS-1].v;
    commit_pkt_o.illegal = exc_r[STAGE_ELS-1].illegal;
    commit_pkt_o.pc      = exc_r[STAGE_ELS-1].pc;
  end

  // Each pipe result lands on a pending write that no other pipe has filled
  assert property (@(posedge clk_i) disable iff (!rst_n_i) int_v_i |-> stage_r[0].w_v)
    else $error("integer result without a pending write");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mul_v_i |-> stage_r[MUL_LATENCY-1].w_v && (stage_r[MUL_LATENCY-1].rd_data == '0))
    else $error("two pipes merged into one instruction");

endmodule

//--- design/calc_pipe_long.sv
/* Long pipe. Restoring unsigned divider, one quotient bit per cycle, which
   holds its result until the completion unit grants the writeback slot. */
`timescale 1ns/100ps

module calc_pipe_long
  (input                             clk_i
   , input                           rst_n_i
   , input  calc_pkg::dispatch_pkt_s reservation_i
   , input                           yumi_i
   , output logic                    ready_o
   , output calc_pkg::wb_pkt_s       wb_pkt_o
   , output logic                    v_o
   );

  import calc_pkg::*;

  logic                  start;
  logic                  busy_r;
  logic                  done_r;
  logic [LOG_DATA_W-1:0] cnt_r;
  logic [DATA_W-1:0]     rem_r;
  logic [DATA_W-1:0]     quo_r;
  logic [DATA_W-1:0]     divisor_r;
  logic                  is_rem_r;
  logic [REG_ADDR_W-1:0] rd_addr_r;
  logic [DATA_W:0]       shifted;
  logic [DATA_W:0]       diff;

  assign start = reservation_i.v & ~reservation_i.illegal
                 & (reservation_i.op inside {OP_DIVU, OP_REMU});

  // Dividend bits shift out of quo_r while quotient bits shift in.
  // A zero divisor never borrows, giving all ones and the dividend
  assign shifted = {rem_r, quo_r[DATA_W-1]};
  assign diff    = shifted - {1'b0, divisor_r};

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
    end
    else if (start)
      busy_r <= 1'b1;
    else if (busy_r && (cnt_r == LOG_DATA_W'(DATA_W-1)))
    begin
      busy_r <= 1'b0;
      done_r <= 1'b1;
    end
    else if (yumi_i)
      done_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      rem_r     <= '0;
      quo_r     <= reservation_i.rs1;
      divisor_r <= reservation_i.rs2;
      cnt_r     <= '0;
      is_rem_r  <= (reservation_i.op == OP_REMU);
      rd_addr_r <= reservation_i.rd_addr;
    end
    else if (busy_r)
    begin
      rem_r <= diff[DATA_W] ? shifted[DATA_W-1:0] : diff[DATA_W-1:0];
      quo_r <= {quo_r[DATA_W-2:0], ~diff[DATA_W]};
      cnt_r <= cnt_r + 1'b1;
    end
  end

  assign ready_o = ~busy_r & ~done_r;
  assign v_o     = done_r;

  always_comb
  begin
    wb_pkt_o.w_v     = done_r;
    wb_pkt_o.rd_addr = rd_addr_r;
    wb_pkt_o.rd_data = is_rem_r ? rem_r : quo_r;
  end

  // Issuer must wait for ready, completion may only grant a held result
  assert property (@(posedge clk_i) disable iff (!rst_n_i) start |-> ready_o)
    else $error("divide started while busy");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) yumi_i |-> v_o)
    else $error("long result granted without valid");

endmodule

//--- design/calc_pipe_mul.sv
/* Multiplier pipe. Registers the operands, then the low half of the product,
   so the result merges into completion stage MUL_LATENCY. */
`timescale 1ns/100ps

module calc_pipe_mul
  (input                                 clk_i
   , input                               rst_n_i
   , input  calc_pkg::dispatch_pkt_s     reservation_i
   , output logic [calc_pkg::DATA_W-1:0] data_o
   , output logic                        v_o
   );

  import calc_pkg::*;

  logic              start;
  logic              v1_r;
  logic              v2_r;
  logic [DATA_W-1:0] a_r;
  logic [DATA_W-1:0] b_r;
  logic [DATA_W-1:0] prod_r;

  assign start = reservation_i.v & ~reservation_i.illegal & (reservation_i.op == OP_MUL);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      v1_r <= 1'b0;
      v2_r <= 1'b0;
    end
    else
    begin
      v1_r <= start;
      v2_r <= v1_r;
    end
  end

  always_ff @(posedge clk_i)
  begin
    a_r    <= reservation_i.rs1;
    b_r    <= reservation_i.rs2;
    prod_r <= a_r * b_r;
  end

  assign data_o = prod_r;
  assign v_o    = v2_r;

endmodule

//--- design/calc_pipe_int.sv
/* Integer pipe. ALU result is combinational and lands in completion stage 1,
   branch compares are registered into the branch packet. */
`timescale 1ns/100ps

module calc_pipe_int
  (input                                 clk_i
   , input                               rst_n_i
   , input  calc_pkg::dispatch_pkt_s     reservation_i
   , output logic [calc_pkg::DATA_W-1:0] data_o
   , output logic                        v_o
   , output calc_pkg::br_pkt_s           br_pkt_o
   );

  import calc_pkg::*;

  logic [DATA_W-1:0] src_b;
  logic              is_alu;
  logic              is_branch;
  logic              rs_equal;
  br_pkt_s           br_pkt_n;

  assign src_b     = reservation_i.use_imm ? reservation_i.imm : reservation_i.rs2;
  assign is_alu    = reservation_i.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
                                              OP_XOR, OP_SLL, OP_SRL, OP_SLT};
  assign is_branch = reservation_i.op inside {OP_BEQ, OP_BNE};
  assign v_o       = reservation_i.v & ~reservation_i.illegal & is_alu;

  always_comb
  begin
    case (reservation_i.op)
      OP_ADD:  data_o = reservation_i.rs1 + src_b;
      OP_SUB:  data_o = reservation_i.rs1 - src_b;
      OP_AND:  data_o = reservation_i.rs1 & src_b;
      OP_OR:   data_o = reservation_i.rs1 | src_b;
      OP_XOR:  data_o = reservation_i.rs1 ^ src_b;
      OP_SLL:  data_o = reservation_i.rs1 << src_b[LOG_DATA_W-1:0];
      OP_SRL:  data_o = reservation_i.rs1 >> src_b[LOG_DATA_W-1:0];
      OP_SLT:  data_o = DATA_W'($signed(reservation_i.rs1) < $signed(src_b));
      default: data_o = '0;
    endcase
  end

  // Branches always compare the two registers
  assign rs_equal = (reservation_i.rs1 == reservation_i.rs2);

  always_comb
  begin
    br_pkt_n.v      = reservation_i.v & ~reservation_i.illegal & is_branch;
    br_pkt_n.taken  = (reservation_i.op == OP_BEQ) ? rs_equal : ~rs_equal;
    br_pkt_n.target = reservation_i.pc + reservation_i.imm;
  end

  always_ff @(posedge clk_i)
  begin
    br_pkt_o <= br_pkt_n;
    if (!rst_n_i)
      br_pkt_o.v <= 1'b0;
  end

endmodule

//--- design/calc_bypass.sv
/* Operand bypass. Replaces stale source data of the dispatch packet with
   results that are still travelling down the completion stages. */
`timescale 1ns/100ps

module calc_bypass
  (input  calc_pkg::dispatch_pkt_s                                 dispatch_i
   , input  calc_pkg::wb_pkt_s [calc_pkg::STAGE_ELS-1:0]           stage_r_i
   , input  logic [calc_pkg::STAGE_ELS-1:0][calc_pkg::DATA_W-1:0] stage_data_n_i
   , output calc_pkg::dispatch_pkt_s                               reservation_n_o
   );

  import calc_pkg::*;

  logic [STAGE_ELS-1:0] match_rs1;
  logic [STAGE_ELS-1:0] match_rs2;
  logic [STAGE_ELS:0]   sel_rs1;
  logic [STAGE_ELS:0]   sel_rs2;

  // Youngest matching stage wins, top bit selects the packet's own data
  function automatic logic [STAGE_ELS:0] pick_youngest(input logic [STAGE_ELS-1:0] match);
    logic [STAGE_ELS:0] sel;
    logic               found;
    sel   = '0;
    found = 1'b0;
    for (int i = 0; i < STAGE_ELS; i++)
    begin
      sel[i] = match[i] & ~found;
      found  = found | match[i];
    end
    sel[STAGE_ELS] = ~found;
    return sel;
  endfunction

  function automatic logic [DATA_W-1:0] fwd_mux
    (input logic [STAGE_ELS:0]              sel
     , input logic [DATA_W-1:0]             own
     , input logic [STAGE_ELS-1:0][DATA_W-1:0] fwd);
    logic [DATA_W-1:0] data;
    data = sel[STAGE_ELS] ? own : '0;
    for (int i = 0; i < STAGE_ELS; i++)
      data |= sel[i] ? fwd[i] : '0;
    return data;
  endfunction

  always_comb
  begin
    for (int i = 0; i < STAGE_ELS; i++)
    begin
      match_rs1[i] = stage_r_i[i].w_v && (stage_r_i[i].rd_addr != '0)
                     && (stage_r_i[i].rd_addr == dispatch_i.rs1_addr);
      match_rs2[i] = stage_r_i[i].w_v && (stage_r_i[i].rd_addr != '0)
                     && (stage_r_i[i].rd_addr == dispatch_i.rs2_addr);
    end
  end

  assign sel_rs1 = pick_youngest(match_rs1);
  assign sel_rs2 = pick_youngest(match_rs2);

  always_comb
  begin
    reservation_n_o     = dispatch_i;
    reservation_n_o.rs1 = fwd_mux(sel_rs1, dispatch_i.rs1, stage_data_n_i);
    reservation_n_o.rs2 = fwd_mux(sel_rs2, dispatch_i.rs2, stage_data_n_i);
  end

  always_comb
  begin
    if (dispatch_i.v)
      assert final ($onehot(sel_rs1) && $onehot(sel_rs2))
        else $error("bypass select is not one-hot");
  end

endmodule

//--- design/calc_pkg.sv
/* Widths, stage counts, opcodes and packet types of the integer execution back end.
   Every RTL module of the back end imports this package. */
package calc_pkg;

  localparam int DATA_W      = 32;
  localparam int REG_ADDR_W  = 5;
  localparam int PC_W        = 32;
  localparam int LOG_DATA_W  = $clog2(DATA_W);

  // Completion stages, the last one feeds writeback and commit
  localparam int STAGE_ELS   = 4;
  localparam int MUL_LATENCY = 3;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SLT,
    OP_MUL,
    OP_DIVU,
    OP_REMU,
    OP_BEQ,
    OP_BNE
  } calc_op_e;

  typedef struct packed {
    logic                  v;
    logic [PC_W-1:0]       pc;
    calc_op_e              op;
    logic                  use_imm;
    logic                  illegal;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [DATA_W-1:0]     rs1;
    logic [DATA_W-1:0]     rs2;
    logic [DATA_W-1:0]     imm;
  } dispatch_pkt_s;

  typedef struct packed {
    logic                  w_v;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0]     rd_data;
  } wb_pkt_s;

  typedef struct packed {
    logic            v;
    logic            illegal;
    logic [PC_W-1:0] pc;
  } exc_stage_s;

  typedef struct packed {
    logic            v;
    logic            taken;
    logic [PC_W-1:0] target;
  } br_pkt_s;

  typedef struct packed {
    logic            v;
    logic            illegal;
    logic [PC_W-1:0] pc;
  } commit_pkt_s;

endpackage
